/* rtl/rv_core_pkg.sv */
// RV32I pipeline shared types: widths, opcodes, control enums and stage payloads
package rv_core_pkg;

	//////////////////////////////////////////////////
	// Widths and constants
	//////////////////////////////////////////////////
	localparam int XLEN       = 32;	// Word width
	localparam int REG_ADDR_W = 5;	// 32 architectural registers

	typedef logic [XLEN-1:0]       word_t;
	typedef logic [REG_ADDR_W-1:0] reg_addr_t;

	// Base opcodes kept by this core
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;

	localparam word_t NOP_INSTR = 32'h0000_0013;	// addi x0, x0, 0

	//////////////////////////////////////////////////
	// Control enums
	//////////////////////////////////////////////////
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_SRA,
		ALU_PASS_B	// lui, operand b straight through
	} alu_op_e;

	typedef enum logic [1:0] {
		WB_ALU,
		WB_PC4,		// Link value of jal / jalr
		WB_LOAD
	} wb_sel_e;

	typedef enum logic [1:0] {
		FWD_REGFILE,
		FWD_EX,
		FWD_MEM,
		FWD_WB
	} fwd_sel_e;

	//////////////////////////////////////////////////
	// Stage payloads
	//////////////////////////////////////////////////
	typedef struct packed {
		logic  valid;
		word_t pc;
		word_t instr;
	} if_id_t;

	typedef struct packed {
		logic      valid;
		word_t     pc;
		word_t     op_a;		// rs1 or PC
		word_t     op_b;		// rs2 or immediate
		word_t     store_data;	// Forwarded rs2
		word_t     imm;
		reg_addr_t rd;
		logic      wr_en;
		alu_op_e   alu_op;
		wb_sel_e   wb_sel;
		logic      is_load;
		logic      is_store;
		logic      is_branch;
		logic [2:0] funct3;	// Branch condition
		logic      is_jal;
		logic      is_jalr;
	} id_ex_t;

	typedef struct packed {
		logic      valid;
		word_t     result;	// Writeback value unless load
		word_t     addr;
		word_t     store_data;
		reg_addr_t rd;
		logic      wr_en;
		logic      is_load;
		logic      is_store;
	} ex_mem_t;

	typedef struct packed {
		logic      valid;
		word_t     wdata;
		reg_addr_t rd;
		logic      wr_en;
	} mem_wb_t;

	// Data port, request held until grant
	typedef struct packed {
		logic  valid;
		logic  write;
		word_t addr;
		word_t wdata;
	} dmem_req_t;

	typedef struct packed {
		logic  grant;
		word_t rdata;	// Valid in grant cycle only
	} dmem_rsp_t;

endpackage

/* rtl/rv_fetch.sv */
// Fetch stage: PC register, next-PC select and the IF/ID register
`timescale 1ns/1ps

module rv_fetch #(
	parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic                i_clk,
	input  logic                i_reset,
	input  logic                i_enable,		// Low while data port waits
	input  logic                i_hold,			// Load-use stall
	input  logic                i_redirect,
	input  rv_core_pkg::word_t  i_redirect_pc,
	output rv_core_pkg::word_t  o_imem_addr,
	input  rv_core_pkg::word_t  i_imem_data,	// Answered in same cycle
	input  logic                i_flush,
	output rv_core_pkg::if_id_t o_if_id
);

	rv_core_pkg::word_t pc;

	assign o_imem_addr = pc;

	// Not-taken prediction, redirect from EX wins
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			pc <= RESET_PC;
		end else if (i_enable) begin
			if (i_redirect) begin
				pc <= i_redirect_pc;
			end else if (!i_hold) begin
				pc <= pc + 32'd4;
			end
		end
	end

	//////////////////////////////////////////////////
	// IF/ID register
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_if_id.valid <= 1'b0;
			o_if_id.instr <= rv_core_pkg::NOP_INSTR;
		end else if (i_enable) begin
			if (i_flush) begin
				o_if_id.valid <= 1'b0;	// Wrong-path slot
				o_if_id.instr <= rv_core_pkg::NOP_INSTR;
			end else if (!i_hold) begin
				o_if_id <= '{valid: 1'b1, pc: pc, instr: i_imem_data};
			end
		end
	end

endmodule

/* rtl/rv_decode.sv */
// Decode stage: control decode, immediates, register file, forwarding and ID/EX register
`timescale 1ns/1ps

module rv_decode (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  logic                   i_enable,
	input  logic                   i_flush,		// Bubble into ID/EX
	input  rv_core_pkg::if_id_t    i_if_id,
	input  rv_core_pkg::mem_wb_t   i_mem_wb,		// Register file write port
	input  rv_core_pkg::word_t     i_ex_result,
	input  rv_core_pkg::word_t     i_mem_result,
	input  rv_core_pkg::fwd_sel_e  i_fwd_a,
	input  rv_core_pkg::fwd_sel_e  i_fwd_b,
	output rv_core_pkg::reg_addr_t o_rs1,
	output rv_core_pkg::reg_addr_t o_rs2,
	output logic                   o_use_rs1,
	output logic                   o_use_rs2,
	output rv_core_pkg::id_ex_t    o_id_ex
);

	rv_core_pkg::word_t  instr;
	logic [6:0]          opcode;
	rv_core_pkg::word_t  regs [32];
	rv_core_pkg::word_t  rs1_val;
	rv_core_pkg::word_t  rs2_val;
	rv_core_pkg::word_t  imm;
	rv_core_pkg::id_ex_t id_ex_d;
	logic                use_rs1;
	logic                use_rs2;
	logic                sel_pc_a;	// PC into operand a
	logic                sel_imm_b;	// Immediate into operand b

	assign instr  = i_if_id.instr;
	assign opcode = instr[6:0];
	assign o_rs1  = instr[19:15];
	assign o_rs2  = instr[24:20];

	// Sources only count for a live instruction
	assign o_use_rs1 = i_if_id.valid && use_rs1;
	assign o_use_rs2 = i_if_id.valid && use_rs2;

	//////////////////////////////////////////////////
	// Register file
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_mem_wb.valid && i_mem_wb.wr_en && i_mem_wb.rd != '0) begin
			regs[i_mem_wb.rd] <= i_mem_wb.wdata;
		end
	end

	// Read with write-through from WB
	function automatic rv_core_pkg::word_t rf_read(input rv_core_pkg::reg_addr_t idx);
		if (idx == '0) begin
			return '0;	// x0 hardwired
		end
		if (i_mem_wb.valid && i_mem_wb.wr_en && i_mem_wb.rd == idx) begin
			return i_mem_wb.wdata;
		end
		return regs[idx];
	endfunction

	function automatic rv_core_pkg::word_t fwd_mux(input rv_core_pkg::fwd_sel_e sel,
			input rv_core_pkg::word_t rf_val);
		case (sel)
			rv_core_pkg::FWD_EX:  return i_ex_result;		// Combinational EX result
			rv_core_pkg::FWD_MEM: return i_mem_result;	// Includes load data
			rv_core_pkg::FWD_WB:  return i_mem_wb.wdata;
			default:              return rf_val;
		endcase
	endfunction

	// funct3 / funct7[5] to ALU op, sub only for register form
	function automatic rv_core_pkg::alu_op_e alu_decode(input logic [2:0] f3,
			input logic f7_5, input logic is_reg);
		case (f3)
			3'b000:  return (is_reg && f7_5) ? rv_core_pkg::ALU_SUB : rv_core_pkg::ALU_ADD;
			3'b001:  return rv_core_pkg::ALU_SLL;
			3'b010:  return rv_core_pkg::ALU_SLT;
			3'b011:  return rv_core_pkg::ALU_SLTU;
			3'b100:  return rv_core_pkg::ALU_XOR;
			3'b101:  return f7_5 ? rv_core_pkg::ALU_SRA : rv_core_pkg::ALU_SRL;
			3'b110:  return rv_core_pkg::ALU_OR;
			default: return rv_core_pkg::ALU_AND;
		endcase
	endfunction

	always_comb begin
		rs1_val = fwd_mux(i_fwd_a, rf_read(o_rs1));
		rs2_val = fwd_mux(i_fwd_b, rf_read(o_rs2));
	end

	//////////////////////////////////////////////////
	// Control decode and operand select
	//////////////////////////////////////////////////
	always_comb begin
		id_ex_d        = '0;
		id_ex_d.valid  = i_if_id.valid && !i_flush;
		id_ex_d.pc     = i_if_id.pc;
		id_ex_d.rd     = instr[11:7];
		id_ex_d.funct3 = instr[14:12];
		id_ex_d.alu_op = rv_core_pkg::ALU_ADD;
		id_ex_d.wb_sel = rv_core_pkg::WB_ALU;
		use_rs1        = 1'b0;
		use_rs2        = 1'b0;
		sel_pc_a       = 1'b0;
		sel_imm_b      = 1'b1;
		imm            = {{20{instr[31]}}, instr[31:20]};	// I-type default
		case (opcode)
			rv_core_pkg::OPC_OP: begin
				id_ex_d.wr_en  = 1'b1;
				id_ex_d.alu_op = alu_decode(instr[14:12], instr[30], 1'b1);
				use_rs1        = 1'b1;
				use_rs2        = 1'b1;
				sel_imm_b      = 1'b0;
			end
			rv_core_pkg::OPC_OP_IMM: begin
				id_ex_d.wr_en  = 1'b1;
				id_ex_d.alu_op = alu_decode(instr[14:12], instr[30], 1'b0);
				use_rs1        = 1'b1;
			end
			rv_core_pkg::OPC_LUI: begin
				id_ex_d.wr_en  = 1'b1;
				id_ex_d.alu_op = rv_core_pkg::ALU_PASS_B;
				imm            = {instr[31:12], 12'b0};
			end
			rv_core_pkg::OPC_AUIPC: begin
				id_ex_d.wr_en = 1'b1;
				imm           = {instr[31:12], 12'b0};
				sel_pc_a      = 1'b1;
			end
			rv_core_pkg::OPC_LOAD: begin
				id_ex_d.wr_en   = 1'b1;
				id_ex_d.is_load = 1'b1;
				id_ex_d.wb_sel  = rv_core_pkg::WB_LOAD;
				use_rs1         = 1'b1;
			end
			rv_core_pkg::OPC_STORE: begin
				id_ex_d.is_store = 1'b1;
				use_rs1          = 1'b1;
				use_rs2          = 1'b1;
				imm              = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			rv_core_pkg::OPC_BRANCH: begin
				id_ex_d.is_branch = 1'b1;
				use_rs1           = 1'b1;
				use_rs2           = 1'b1;
				sel_imm_b         = 1'b0;	// Compare rs1 with rs2
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			rv_core_pkg::OPC_JAL: begin
				id_ex_d.wr_en  = 1'b1;
				id_ex_d.is_jal = 1'b1;
				id_ex_d.wb_sel = rv_core_pkg::WB_PC4;
				sel_pc_a       = 1'b1;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			rv_core_pkg::OPC_JALR: begin
				id_ex_d.wr_en   = 1'b1;
				id_ex_d.is_jalr = 1'b1;
				id_ex_d.wb_sel  = rv_core_pkg::WB_PC4;
				use_rs1         = 1'b1;
			end
			default: ;	// Unsupported, no side effects
		endcase
		id_ex_d.imm        = imm;
		id_ex_d.op_a       = sel_pc_a ? i_if_id.pc : rs1_val;
		id_ex_d.op_b       = sel_imm_b ? imm : rs2_val;
		id_ex_d.store_data = rs2_val;
	end

	// ID/EX register
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_id_ex.valid <= 1'b0;
		end else if (i_enable) begin
			o_id_ex <= id_ex_d;
		end
	end

endmodule

/* rtl/rv_execute.sv */
// Execute stage: ALU, branch and jump resolution, result select and EX/MEM register
`timescale 1ns/1ps

module rv_execute (
	input  logic                 i_clk,
	input  logic                 i_reset,
	input  logic                 i_enable,
	input  rv_core_pkg::id_ex_t  i_id_ex,
	output rv_core_pkg::word_t   o_ex_result,	// Forwarded into decode
	output logic                 o_redirect,
	output rv_core_pkg::word_t   o_redirect_pc,
	output rv_core_pkg::ex_mem_t o_ex_mem
);

	rv_core_pkg::word_t   a;
	rv_core_pkg::word_t   b;
	rv_core_pkg::word_t   alu_out;
	rv_core_pkg::word_t   pc4;
	logic                 taken;
	rv_core_pkg::ex_mem_t ex_mem_d;

	assign a   = i_id_ex.op_a;
	assign b   = i_id_ex.op_b;
	assign pc4 = i_id_ex.pc + 32'd4;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (i_id_ex.alu_op)
			rv_core_pkg::ALU_ADD:  alu_out = a + b;	// Also addresses and jump targets
			rv_core_pkg::ALU_SUB:  alu_out = a - b;
			rv_core_pkg::ALU_AND:  alu_out = a & b;
			rv_core_pkg::ALU_OR:   alu_out = a | b;
			rv_core_pkg::ALU_XOR:  alu_out = a ^ b;
			rv_core_pkg::ALU_SLT:  alu_out = {31'b0, $signed(a) < $signed(b)};
			rv_core_pkg::ALU_SLTU: alu_out = {31'b0, a < b};
			rv_core_pkg::ALU_SLL:  alu_out = a << b[4:0];
			rv_core_pkg::ALU_SRL:  alu_out = a >> b[4:0];
			rv_core_pkg::ALU_SRA:  alu_out = $signed(a) >>> b[4:0];
			default:               alu_out = b;	// PASS_B
		endcase
	end

	// Branch condition from funct3
	always_comb begin
		case (i_id_ex.funct3)
			3'b000:  taken = (a == b);	// beq
			3'b001:  taken = (a != b);	// bne
			3'b100:  taken = $signed(a) < $signed(b);
			3'b101:  taken = $signed(a) >= $signed(b);
			3'b110:  taken = a < b;		// bltu
			3'b111:  taken = a >= b;
			default: taken = 1'b0;
		endcase
	end

	// Predicted not taken, so any taken control transfer redirects
	assign o_redirect = i_id_ex.valid &&
		((i_id_ex.is_branch && taken) || i_id_ex.is_jal || i_id_ex.is_jalr);

	assign o_redirect_pc = i_id_ex.is_branch ? i_id_ex.pc + i_id_ex.imm :
		i_id_ex.is_jalr ? {alu_out[31:1], 1'b0} : alu_out;

	// Link value for jumps
	assign o_ex_result = (i_id_ex.wb_sel == rv_core_pkg::WB_PC4) ? pc4 : alu_out;

	assign ex_mem_d = '{
		valid:      i_id_ex.valid,
		result:     o_ex_result,
		addr:       alu_out,
		store_data: i_id_ex.store_data,
		rd:         i_id_ex.rd,
		wr_en:      i_id_ex.wr_en,
		is_load:    i_id_ex.is_load,
		is_store:   i_id_ex.is_store
	};

	// EX/MEM register
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_ex_mem.valid <= 1'b0;
		end else if (i_enable) begin
			o_ex_mem <= ex_mem_d;
		end
	end

endmodule

/* rtl/rv_memory.sv */
// Memory stage: data-port request/grant master, load return and MEM/WB register
`timescale 1ns/1ps

module rv_memory (
	input  logic                   i_clk,
	input  logic                   i_reset,
	input  rv_core_pkg::ex_mem_t   i_ex_mem,
	output rv_core_pkg::dmem_req_t o_dmem_req,
	input  rv_core_pkg::dmem_rsp_t i_dmem_rsp,
	output logic                   o_mem_wait,		// Stalls whole pipeline
	output rv_core_pkg::word_t     o_mem_result,
	output rv_core_pkg::mem_wb_t   o_mem_wb
);

	logic mem_op;

	assign mem_op = i_ex_mem.valid && (i_ex_mem.is_load || i_ex_mem.is_store);

	// Request comes straight off EX/MEM, which holds until grant
	assign o_dmem_req = '{
		valid: mem_op,
		write: i_ex_mem.is_store,
		addr:  i_ex_mem.addr,
		wdata: i_ex_mem.store_data
	};

	assign o_mem_wait = mem_op && !i_dmem_rsp.grant;

	// Read data only meaningful in grant cycle
	assign o_mem_result = i_ex_mem.is_load ? i_dmem_rsp.rdata : i_ex_mem.result;

	//////////////////////////////////////////////////
	// MEM/WB register
	//////////////////////////////////////////////////
	always_ff @(posedge i_clk) begin
		if (i_reset) begin
			o_mem_wb.valid <= 1'b0;
		end else if (o_mem_wait) begin
			o_mem_wb.valid <= 1'b0;	// Bubble while waiting
		end else begin
			o_mem_wb <= '{
				valid: i_ex_mem.valid,
				wdata: o_mem_result,
				rd:    i_ex_mem.rd,
				wr_en: i_ex_mem.wr_en
			};
		end
	end

	// Whole request frozen from valid until grant
	a_req_stable: assert property (@(posedge i_clk) disable iff (i_reset)
		o_dmem_req.valid && !i_dmem_rsp.grant |=> $stable(o_dmem_req))
		else $error("data request changed while waiting for grant");

endmodule

/* rtl/rv_hazard_unit.sv */
// Hazard unit: forwarding select, load-use stall, flush and pipeline enable
`timescale 1ns/1ps

module rv_hazard_unit (
	input  rv_core_pkg::reg_addr_t i_rs1,
	input  rv_core_pkg::reg_addr_t i_rs2,
	input  logic                   i_use_rs1,
	input  logic                   i_use_rs2,
	input  rv_core_pkg::id_ex_t    i_id_ex,
	input  rv_core_pkg::ex_mem_t   i_ex_mem,
	input  rv_core_pkg::mem_wb_t   i_mem_wb,
	input  logic                   i_redirect,
	input  logic                   i_mem_wait,
	output rv_core_pkg::fwd_sel_e  o_fwd_a,
	output rv_core_pkg::fwd_sel_e  o_fwd_b,
	output logic                   o_enable,
	output logic                   o_hold,
	output logic                   o_flush_if_id,
	output logic                   o_flush_id_ex
);

	logic load_use;

	// Youngest writer wins, x0 never forwarded
	function automatic rv_core_pkg::fwd_sel_e pick(input rv_core_pkg::reg_addr_t rs,
			input logic use_rs);
		if (!use_rs || rs == '0) begin
			return rv_core_pkg::FWD_REGFILE;
		end
		if (i_id_ex.valid && i_id_ex.wr_en && i_id_ex.rd == rs) begin
			return rv_core_pkg::FWD_EX;
		end
		if (i_ex_mem.valid && i_ex_mem.wr_en && i_ex_mem.rd == rs) begin
			return rv_core_pkg::FWD_MEM;
		end
		if (i_mem_wb.valid && i_mem_wb.wr_en && i_mem_wb.rd == rs) begin
			return rv_core_pkg::FWD_WB;
		end
		return rv_core_pkg::FWD_REGFILE;
	endfunction

	always_comb begin
		o_fwd_a = pick(i_rs1, i_use_rs1);
		o_fwd_b = pick(i_rs2, i_use_rs2);
	end

	//////////////////////////////////////////////////
	// Stall and flush
	//////////////////////////////////////////////////
	// Load data not ready in EX, wait one cycle for MEM forward
	assign load_use = i_id_ex.valid && i_id_ex.is_load && i_id_ex.rd != '0 &&
		((i_use_rs1 && i_rs1 == i_id_ex.rd) || (i_use_rs2 && i_rs2 == i_id_ex.rd));

	assign o_enable      = !i_mem_wait;
	assign o_hold        = load_use && !i_redirect;	// Flush wins
	assign o_flush_if_id = i_redirect;
	assign o_flush_id_ex = i_redirect || load_use;	// Bubble or wrong path

	// A load in EX never redirects, so the stall and flush never share a slot
	always_comb begin
		a_no_redirect_on_stall: assert final (!(load_use && i_redirect))
			else $error("load-use stall and redirect in the same cycle");
	end

endmodule

/* rtl/rv_core.sv */
// RV32I five-stage core top: stage and hazard unit wiring
`timescale 1ns/1ps

module rv_core #(
	parameter rv_core_pkg::word_t RESET_PC = 32'h0000_0000
) (
	input  logic                   i_clk,
	input  logic                   i_reset,
	output rv_core_pkg::word_t     o_imem_addr,
	input  rv_core_pkg::word_t     i_imem_data,
	output rv_core_pkg::dmem_req_t o_dmem_req,
	input  rv_core_pkg::dmem_rsp_t i_dmem_rsp
);

	//////////////////////////////////////////////////
	// Stage payloads and control
	//////////////////////////////////////////////////
	rv_core_pkg::if_id_t    if_id;
	rv_core_pkg::id_ex_t    id_ex;
	rv_core_pkg::ex_mem_t   ex_mem;
	rv_core_pkg::mem_wb_t   mem_wb;
	rv_core_pkg::word_t     ex_result;		// EX forward source
	rv_core_pkg::word_t     mem_result;		// MEM forward source
	rv_core_pkg::word_t     redirect_pc;
	logic                   redirect;
	rv_core_pkg::reg_addr_t id_rs1;
	rv_core_pkg::reg_addr_t id_rs2;
	logic                   id_use_rs1;
	logic                   id_use_rs2;
	rv_core_pkg::fwd_sel_e  fwd_a;
	rv_core_pkg::fwd_sel_e  fwd_b;
	logic                   mem_wait;
	logic                   enable;
	logic                   hold;
	logic                   flush_if_id;
	logic                   flush_id_ex;

	rv_fetch #(
		.RESET_PC(RESET_PC)
	) fetch_i (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_enable     (enable),
		.i_hold       (hold),
		.i_redirect   (redirect),
		.i_redirect_pc(redirect_pc),
		.o_imem_addr  (o_imem_addr),
		.i_imem_data  (i_imem_data),
		.i_flush      (flush_if_id),
		.o_if_id      (if_id)
	);

	rv_decode decode_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_enable    (enable),
		.i_flush     (flush_id_ex),
		.i_if_id     (if_id),
		.i_mem_wb    (mem_wb),
		.i_ex_result (ex_result),
		.i_mem_result(mem_result),
		.i_fwd_a     (fwd_a),
		.i_fwd_b     (fwd_b),
		.o_rs1       (id_rs1),
		.o_rs2       (id_rs2),
		.o_use_rs1   (id_use_rs1),
		.o_use_rs2   (id_use_rs2),
		.o_id_ex     (id_ex)
	);

	rv_execute execute_i (
		.i_clk        (i_clk),
		.i_reset      (i_reset),
		.i_enable     (enable),
		.i_id_ex      (id_ex),
		.o_ex_result  (ex_result),
		.o_redirect   (redirect),
		.o_redirect_pc(redirect_pc),
		.o_ex_mem     (ex_mem)
	);

	rv_memory memory_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_ex_mem    (ex_mem),
		.o_dmem_req  (o_dmem_req),
		.i_dmem_rsp  (i_dmem_rsp),
		.o_mem_wait  (mem_wait),
		.o_mem_result(mem_result),
		.o_mem_wb    (mem_wb)
	);

	rv_hazard_unit hazard_i (
		.i_rs1        (id_rs1),
		.i_rs2        (id_rs2),
		.i_use_rs1    (id_use_rs1),
		.i_use_rs2    (id_use_rs2),
		.i_id_ex      (id_ex),
		.i_ex_mem     (ex_mem),
		.i_mem_wb     (mem_wb),
		.i_redirect   (redirect),
		.i_mem_wait   (mem_wait),
		.o_fwd_a      (fwd_a),
		.o_fwd_b      (fwd_b),
		.o_enable     (enable),
		.o_hold       (hold),
		.o_flush_if_id(flush_if_id),
		.o_flush_id_ex(flush_id_ex)
	);

endmodule

/* dv/rv_core_tb.sv */
// RV32I core testbench with instruction and data memory models, a store log and directed program tests
`timescale 1ns/1ps

module rv_core_tb;

	localparam rv_core_pkg::word_t RESET_PC = 32'h0000_0200;	// Deliberately non-zero
	localparam int IMEM_WORDS = 64;
	localparam int DMEM_WORDS = 64;
	localparam int TIMEOUT    = 2000;	// Cycles per program
	localparam logic [6:0] F7_ALT = 7'b0100000;	// sub / sra
	localparam rv_core_pkg::word_t MARK = 32'h0000_05A5;	// Branch marker data

	logic                   clk;
	logic                   reset;
	rv_core_pkg::word_t     imem_addr;
	rv_core_pkg::word_t     imem_data;
	rv_core_pkg::word_t     imem_off;
	rv_core_pkg::dmem_req_t dmem_req;
	rv_core_pkg::dmem_rsp_t dmem_rsp;

	rv_core_pkg::word_t imem [IMEM_WORDS];
	rv_core_pkg::word_t dmem [DMEM_WORDS];
	rv_core_pkg::word_t log_addr_q [$];	// Stores seen on the data port
	rv_core_pkg::word_t log_data_q [$];
	rv_core_pkg::word_t exp_addr_q [$];
	rv_core_pkg::word_t exp_data_q [$];

	int                     n_instr;
	int                     errors;
	int                     checks;
	logic                   bp_en;		// Random grant delay on
	logic [31:0]            lfsr;
	logic                   busy;		// Request accepted and grant pending
	int                     wait_left;
	rv_core_pkg::dmem_req_t held_req;

	rv_core #(
		.RESET_PC(RESET_PC)
	) rv_core_i (
		.i_clk      (clk),
		.i_reset    (reset),
		.o_imem_addr(imem_addr),
		.i_imem_data(imem_data),
		.o_dmem_req (dmem_req),
		.i_dmem_rsp (dmem_rsp)
	);

	always #5 clk = ~clk;

	// Combinational fetch port returns NOP outside the program window
	assign imem_off  = imem_addr - RESET_PC;
	assign imem_data = (imem_off < 4 * IMEM_WORDS) ? imem[imem_off[7:2]] :
		rv_core_pkg::NOP_INSTR;

	// Galois LFSR stepped once per bit drawn
	function automatic int draw_bits(input int n);
		int v;
		v = 0;
		for (int k = 0; k < n; k++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
			v    = (v << 1) | int'(lfsr[0]);
		end
		return v;
	endfunction

	//////////////////////////////////////////////////
	// Data port responder
	//////////////////////////////////////////////////
	always @(negedge clk) begin
		if (dmem_rsp.grant) begin
			busy = 1'b0;	// Last transfer done
		end
		dmem_rsp.grant = 1'b0;
		dmem_rsp.rdata = 32'hBAD0_BAD0;	// Junk outside grant cycle
		// Pending request must hold every field, valid included
		if (busy && dmem_req !== held_req) begin
			errors++;
			$display("FAIL %0t: data request changed while waiting for grant", $time);
			busy = 1'b0;
		end
		if (dmem_req.valid) begin
			if (!busy) begin
				busy      = 1'b1;
				held_req  = dmem_req;
				wait_left = bp_en ? draw_bits(3) : 0;
			end
			if (wait_left == 0) begin
				dmem_rsp.grant = 1'b1;
				if (held_req.write) begin
					dmem[held_req.addr[7:2]] = held_req.wdata;
					log_addr_q.push_back(held_req.addr);
					log_data_q.push_back(held_req.wdata);
				end else begin
					dmem_rsp.rdata = dmem[held_req.addr[7:2]];
				end
			end else begin
				wait_left--;
			end
		end
	end

	//////////////////////////////////////////////////
	// Instruction encoders
	//////////////////////////////////////////////////
	function automatic rv_core_pkg::word_t reg_op(input logic [6:0] f7, input logic [2:0] f3,
			input int rd, input int rs1, input int rs2);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_core_pkg::OPC_OP};
	endfunction

	function automatic rv_core_pkg::word_t imm_form(input logic [6:0] opc, input logic [2:0] f3,
			input int rd, input int rs1, input int imm);
		return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic rv_core_pkg::word_t addi(input int rd, input int rs1, input int imm);
		return imm_form(rv_core_pkg::OPC_OP_IMM, 3'b000, rd, rs1, imm);
	endfunction

	function automatic rv_core_pkg::word_t store_word(input int rs2, input int rs1, input int imm);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], rv_core_pkg::OPC_STORE};
	endfunction

	function automatic rv_core_pkg::word_t upper_imm(input logic [6:0] opc, input int rd,
			input int imm20);
		return {20'(imm20), 5'(rd), opc};
	endfunction

	function automatic rv_core_pkg::word_t branch_off(input logic [2:0] f3, input int rs1,
			input int rs2, input int off);
		logic [12:0] o;
		o = 13'(off);
		return {o[12], o[10:5], 5'(rs2), 5'(rs1), f3, o[4:1], o[11], rv_core_pkg::OPC_BRANCH};
	endfunction

	function automatic rv_core_pkg::word_t jal_off(input int rd, input int off);
		logic [20:0] o;
		o = 21'(off);
		return {o[20], o[10:1], o[11], o[19:12], 5'(rd), rv_core_pkg::OPC_JAL};
	endfunction

	function automatic rv_core_pkg::word_t pc_now();
		return RESET_PC + 32'(4 * n_instr);	// Address of next emitted word
	endfunction

	task automatic emit(input rv_core_pkg::word_t w);
		imem[n_instr] = w;
		n_instr++;
	endtask

	task automatic expect_store(input rv_core_pkg::word_t addr, input rv_core_pkg::word_t data);
		exp_addr_q.push_back(addr);
		exp_data_q.push_back(data);
	endtask

	//////////////////////////////////////////////////
	// Program run and store compare
	//////////////////////////////////////////////////
	task automatic begin_test();
		@(negedge clk);
		reset   = 1'b1;	// Held while the next program loads
		n_instr = 0;
		for (int k = 0; k < IMEM_WORDS; k++) begin
			imem[k] = rv_core_pkg::NOP_INSTR;
		end
		for (int k = 0; k < DMEM_WORDS; k++) begin
			dmem[k] = {16'hC0DE, 16'(k * 4)};	// Word address in low half
		end
		exp_addr_q.delete();
		exp_data_q.delete();
	endtask

	task automatic run_program(input string name);
		int cycles;
		repeat (3) begin
			@(negedge clk);
			checks++;
			if (dmem_req.valid !== 1'b0) begin
				errors++;
				$display("FAIL %0t: %s data request valid during reset", $time, name);
			end
		end
		reset = 1'b0;
		log_addr_q.delete();
		log_data_q.delete();
		checks++;
		if (imem_addr !== RESET_PC) begin
			errors++;
			$display("FAIL %0t: %s first fetch at %h, expected %h", $time, name, imem_addr,
				RESET_PC);
		end
		// Nothing can reach MEM in the first two cycles
		repeat (2) begin
			@(negedge clk);
			checks++;
			if (dmem_req.valid !== 1'b0) begin
				errors++;
				$display("FAIL %0t: %s data request before any memory instruction", $time, name);
			end
		end
		cycles = 0;
		while (log_addr_q.size() < exp_addr_q.size() && cycles < TIMEOUT) begin
			@(posedge clk);
			cycles++;
		end
		if (log_addr_q.size() < exp_addr_q.size()) begin
			errors++;
			$display("ERROR: %s timed out after %0d cycles with %0d of %0d stores", name, cycles,
				log_addr_q.size(), exp_addr_q.size());
		end
		repeat (32) @(posedge clk);	// Room for any stray store
		checks++;
		if (log_addr_q.size() != exp_addr_q.size()) begin
			errors++;
			$display("FAIL %0t: %s saw %0d stores, expected %0d", $time, name, log_addr_q.size(),
				exp_addr_q.size());
		end
		for (int k = 0; k < exp_addr_q.size() && k < log_addr_q.size(); k++) begin
			checks++;
			if (log_addr_q[k] !== exp_addr_q[k] || log_data_q[k] !== exp_data_q[k]) begin
				errors++;
				$display("FAIL %0t: %s store %0d wrote %h to %h, expected %h to %h", $time, name, k,
					log_data_q[k], log_addr_q[k], exp_data_q[k], exp_addr_q[k]);
			end
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests
	//////////////////////////////////////////////////
	task automatic alu_chain();
		rv_core_pkg::word_t auipc_pc;
		begin_test();
		emit(addi(1, 0, 5));
		emit(addi(2, 1, 7));			// EX forward of x1
		emit(reg_op(F7_ALT, 3'b000, 3, 2, 1));	// sub
		emit(store_word(3, 0, 'h00));		// Store data from EX
		emit(reg_op(7'd0, 3'b100, 4, 3, 2));	// xor
		emit(reg_op(7'd0, 3'b001, 5, 4, 1));	// sll
		emit(store_word(4, 0, 'h04));		// From MEM
		emit(store_word(5, 0, 'h08));
		emit(reg_op(7'd0, 3'b010, 6, 3, 5));	// slt
		emit(addi(7, 0, -3));
		emit(reg_op(F7_ALT, 3'b101, 8, 7, 1));	// sra
		emit(reg_op(7'd0, 3'b101, 9, 7, 1));	// srl
		emit(reg_op(7'd0, 3'b011, 10, 7, 1));	// sltu
		emit(store_word(6, 0, 'h0C));
		emit(store_word(8, 0, 'h10));
		emit(store_word(9, 0, 'h14));
		emit(store_word(10, 0, 'h18));
		emit(upper_imm(rv_core_pkg::OPC_LUI, 12, 'h12345));
		emit(addi(12, 12, 'h678));
		emit(store_word(12, 0, 'h1C));
		emit(reg_op(7'd0, 3'b111, 13, 12, 9));	// and
		emit(store_word(13, 0, 'h20));
		emit(reg_op(7'd0, 3'b110, 14, 13, 6));	// or
		emit(store_word(14, 0, 'h24));
		auipc_pc = pc_now();
		emit(upper_imm(rv_core_pkg::OPC_AUIPC, 15, 'h1));
		emit(store_word(15, 0, 'h28));
		emit(jal_off(0, 0));			// Park
		expect_store(32'h00, 32'd12 - 32'd5);
		expect_store(32'h04, 32'd7 ^ 32'd12);
		expect_store(32'h08, 32'd11 << 5);
		expect_store(32'h0C, 32'd1);		// 7 < 352
		expect_store(32'h10, 32'hFFFF_FFFF);	// -3 >>> 5
		expect_store(32'h14, 32'hFFFF_FFFD >> 5);
		expect_store(32'h18, 32'd0);		// Unsigned -3 not below 5
		expect_store(32'h1C, 32'h1234_5678);
		expect_store(32'h20, 32'h1234_5678 & 32'h07FF_FFFF);
		expect_store(32'h24, 32'h0234_5678 | 32'd1);
		expect_store(32'h28, auipc_pc + 32'h0000_1000);
		run_program("alu_chain");
	endtask

	task automatic load_use_stall();
		begin_test();
		dmem['h40 >> 2] = 32'h1000_0001;	// Preloaded operand
		emit(addi(1, 0, 'h123));
		emit(imm_form(rv_core_pkg::OPC_LOAD, 3'b010, 2, 0, 'h40));
		emit(reg_op(7'd0, 3'b000, 3, 2, 1));	// Needs one bubble
		emit(store_word(3, 0, 'h44));
		emit(imm_form(rv_core_pkg::OPC_LOAD, 3'b010, 4, 0, 'h40));
		emit(store_word(4, 0, 'h48));		// Load into store data
		emit(jal_off(0, 0));
		expect_store(32'h44, 32'h1000_0001 + 32'h123);
		expect_store(32'h48, 32'h1000_0001);
		run_program("load_use");
	endtask

	// Branch over a fall-through marker onto a join marker
	task automatic branch_case(input logic [2:0] f3, input int rs1, input int rs2,
			input logic taken, input int slot);
		emit(branch_off(f3, rs1, rs2, 8));
		emit(store_word(31, 0, 'h80 + 8 * slot));
		emit(store_word(31, 0, 'h84 + 8 * slot));
		if (!taken) begin
			expect_store(32'('h80 + 8 * slot), MARK);
		end
		expect_store(32'('h84 + 8 * slot), MARK);
	endtask

	task automatic branch_paths();
		begin_test();
		emit(addi(1, 0, 5));
		emit(addi(2, 0, -3));
		emit(addi(3, 0, 5));
		emit(addi(31, 0, int'(MARK)));
		branch_case(3'b000, 1, 3, 1'b1, 0);	// beq 5 == 5
		branch_case(3'b000, 1, 2, 1'b0, 1);
		branch_case(3'b001, 1, 2, 1'b1, 2);	// bne
		branch_case(3'b001, 1, 3, 1'b0, 3);
		branch_case(3'b100, 2, 1, 1'b1, 4);	// blt -3 < 5
		branch_case(3'b100, 1, 2, 1'b0, 5);
		branch_case(3'b101, 1, 2, 1'b1, 6);	// bge
		branch_case(3'b101, 2, 1, 1'b0, 7);
		branch_case(3'b110, 1, 2, 1'b1, 8);	// bltu with -3 huge as unsigned
		branch_case(3'b110, 2, 1, 1'b0, 9);
		branch_case(3'b111, 2, 1, 1'b1, 10);	// bgeu
		branch_case(3'b111, 1, 2, 1'b0, 11);
		emit(jal_off(0, 0));
		run_program("branches");
	endtask

	task automatic jump_links();
		rv_core_pkg::word_t jal_link;
		rv_core_pkg::word_t jalr_link_a;
		rv_core_pkg::word_t jalr_link_b;
		begin_test();
		jal_link = pc_now() + 32'd4;
		emit(jal_off(1, 12));			// Over two stores
		emit(store_word(0, 0, 'hF0));
		emit(store_word(0, 0, 'hF4));
		emit(store_word(1, 0, 'h60));
		emit(upper_imm(rv_core_pkg::OPC_AUIPC, 6, 0));	// x6 holds the jump base
		jalr_link_a = pc_now() + 32'd4;
		emit(imm_form(rv_core_pkg::OPC_JALR, 3'b000, 7, 6, 16));	// base + 16
		emit(store_word(0, 0, 'hF8));
		emit(store_word(0, 0, 'hFC));
		emit(store_word(7, 0, 'h64));
		jalr_link_b = pc_now() + 32'd4;
		emit(imm_form(rv_core_pkg::OPC_JALR, 3'b000, 8, 6, 29));	// Odd target loses bit 0
		emit(store_word(0, 0, 'hEC));
		emit(store_word(8, 0, 'h68));		// At base + 28
		emit(jal_off(0, 0));
		expect_store(32'h60, jal_link);
		expect_store(32'h64, jalr_link_a);
		expect_store(32'h68, jalr_link_b);
		run_program("jumps");
	endtask

	initial begin
		clk       = 1'b0;
		reset     = 1'b1;
		dmem_rsp  = '0;
		bp_en     = 1'b0;
		lfsr      = 32'h19ecbb03;
		errors    = 0;
		checks    = 0;
		busy      = 1'b0;
		wait_left = 0;
		held_req  = '0;
		n_instr   = 0;
		for (int k = 0; k < IMEM_WORDS; k++) begin
			imem[k] = rv_core_pkg::NOP_INSTR;
		end
		// Second pass repeats everything under random grant delay
		for (int pass = 0; pass < 2; pass++) begin
			bp_en = (pass == 1);
			alu_chain();
			load_use_stall();
			branch_paths();
			jump_links();
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* rv_core.f */
rtl/rv_core_pkg.sv
rtl/rv_fetch.sv
rtl/rv_decode.sv
rtl/rv_execute.sv
rtl/rv_memory.sv
rtl/rv_hazard_unit.sv
rtl/rv_core.sv
dv/rv_core_tb.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rtl/rv_core_pkg.sv
  - rtl/rv_fetch.sv
  - rtl/rv_decode.sv
  - rtl/rv_execute.sv
  - rtl/rv_memory.sv
  - rtl/rv_hazard_unit.sv
  - rtl/rv_core.sv
  - target: simulation
    files:
      - dv/rv_core_tb.sv
